//--- Bender.yml
package:
  name: wrr_arbiter

sources:
  - wrr_pkg.sv
  - wrr_weight_regs.sv
  - wrr_credit_counters.sv
  - wrr_grant_sel.sv
  - wrr_arbiter.sv
  - target: test
    files:
      - wrr_arbiter_props.sv
      - tb_wrr_arbiter.sv

//--- project.f
wrr_pkg.sv
wrr_weight_regs.sv
wrr_credit_counters.sv
wrr_grant_sel.sv
wrr_arbiter.sv
wrr_arbiter_props.sv
tb_wrr_arbiter.sv

//--- tb_wrr_arbiter.sv
module tb_wrr_arbiter;

   timeunit 1ns;
   timeprecision 1ps;

   import wrr_pkg::*;

   localparam int RAND_CYCLES    = 2000;
   // reset, idle check, 1-1-1, 3-1-2, weight 0, reload, random
   localparam int PHASE_CYCLES   = 8 + 20 + 40 + 60 + 100 + 80 + RAND_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * PHASE_CYCLES;

   logic                  clk = 1'b0;
   logic                  resetb;
   logic                  cfg_load;
   weight_t [NUM_REQ-1:0] cfg_weights;
   req_vec_t              req;
   req_vec_t              end_access;
   req_vec_t              gnt;

   // reference model state
   weight_t [NUM_REQ-1:0] m_weights;
   weight_t [NUM_REQ-1:0] m_credit;
   logic                  m_armed;
   logic                  m_update;
   int                    m_ptr;
   arb_state_t            m_state;
   req_vec_t              m_gnt;
   req_vec_t              exp_gnt = '0;

   // requester model
   req_vec_t              in_access;
   int                    remaining [NUM_REQ];
   int                    fixed_len;   // 0 picks a random length
   int                    winners [$];

   logic [15:0]           lfsr = 16'd39656;
   int                    cycle_count = 0;

   wrr_arbiter u_wrr_arbiter
   (
      .clk         (clk),
      .resetb      (resetb),
      .cfg_load    (cfg_load),
      .cfg_weights (cfg_weights),
      .req         (req),
      .end_access  (end_access),
      .gnt         (gnt)
   );

   always #2 clk = ~clk;

   task fail_run;
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
         fail_run();
      end
   endtask

   // one galois step per bit
   function automatic int lfsr_bits(input int n);
      int  r;
      logic b;
      r = 0;
      for (int k = 0; k < n; k++)
      begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b)
         begin
            lfsr = lfsr ^ 16'hB400;
         end
         r = (r << 1) | int'(b);
      end
      return r;
   endfunction

   function automatic int count_of(input int q[$], input int who);
      int n;
      n = 0;
      foreach (q[k])
      begin
         if (q[k] == who)
         begin
            n++;
         end
      end
      return n;
   endfunction

   task model_reset;
      m_weights = '0;
      m_credit  = '0;
      m_armed   = 1'b0;
      m_update  = 1'b0;
      m_ptr     = NUM_REQ - 1;
      m_state   = ST_IDLE;
      m_gnt     = '0;
   endtask

   // advances the model by one clock edge from the old state
   function automatic req_vec_t predict_gnt(input logic load, input weight_t [NUM_REQ-1:0] w_in,
                                            input req_vec_t rq, input req_vec_t ea);
      logic     decide;
      logic     refill;
      req_vec_t take;
      int       win;
      int       idx;
      decide = (m_state == ST_ARMED) && ((m_gnt == '0) || ((m_gnt & ea) != '0));
      refill = 1'b0;
      take   = '0;
      win    = -1;
      if (decide)
      begin
         for (int k = 1; k <= NUM_REQ; k++)
         begin
            idx = (m_ptr + k) % NUM_REQ;
            if ((win < 0) && rq[idx] && (m_credit[idx] != '0))
            begin
               win = idx;
            end
         end
         if (win >= 0)
         begin
            m_gnt     = '0;
            m_gnt[win] = 1'b1;
            take[win]  = 1'b1;
            m_ptr      = win;
         end
         else
         begin
            m_gnt  = '0;
            refill = 1'b1;   // round over
         end
      end
      for (int i = 0; i < NUM_REQ; i++)
      begin
         if (m_update || refill)
         begin
            m_credit[i] = m_weights[i];
         end
         else if (take[i])
         begin
            m_credit[i] = m_credit[i] - 1'b1;
         end
      end
      if ((m_state == ST_IDLE) && m_armed)
      begin
         m_state = ST_ARMED;
      end
      m_update = load;
      if (load)
      begin
         m_weights = w_in;
         m_armed   = 1'b1;
      end
      return m_gnt;
   endfunction

   always @(posedge clk)
   begin
      if (!resetb)
      begin
         model_reset();
         exp_gnt = '0;
      end
      else
      begin
         exp_gnt = predict_gnt(cfg_load, cfg_weights, req, end_access);
      end
   end

   // gnt is stable at the falling edge
   always @(negedge clk)
   begin
      check_equal("gnt", gnt, exp_gnt);
      if (u_wrr_arbiter.u_props.fail_count != 0)
      begin
         $display("an assertion on the arbiter failed");
         fail_run();
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES)
      begin
         $display("run timed out after %0d cycles", cycle_count);
         fail_run();
      end
   end

   task requester_step;
      for (int i = 0; i < NUM_REQ; i++)
      begin
         if (end_access[i])
         begin
            in_access[i] = 1'b0;   // access closed at this edge
         end
         end_access[i] = 1'b0;
         if (gnt[i] && !in_access[i])
         begin
            in_access[i] = 1'b1;
            remaining[i] = (fixed_len != 0) ? fixed_len : 1 + lfsr_bits(2);
            winners.push_back(i);
         end
         if (in_access[i])
         begin
            remaining[i]--;
            if (remaining[i] == 0)
            begin
               end_access[i] = 1'b1;
            end
         end
      end
   endtask

   task tick;
      @(posedge clk);
      #1;
      cfg_load = 1'b0;
      requester_step();
   endtask

   task load_weights(input weight_t w0, input weight_t w1, input weight_t w2);
      cfg_weights = {w2, w1, w0};
      cfg_load    = 1'b1;
      tick();
   endtask

   task wait_winners(input int n);
      while (winners.size() < n)
      begin
         tick();
      end
   endtask

   // drain the bus before loading so the next round starts clean
   task quiesce_and_load(input weight_t w0, input weight_t w1, input weight_t w2);
      req = '0;
      tick();
      while (gnt != '0)
      begin
         tick();
      end
      load_weights(w0, w1, w2);
      tick();
      winners.delete();
   endtask

   initial
   begin
      resetb      = 1'b0;
      cfg_load    = 1'b0;
      cfg_weights = '0;
      req         = '0;
      end_access  = '0;
      in_access   = '0;
      fixed_len   = 1;
      foreach (remaining[i])
      begin
         remaining[i] = 0;
      end
      repeat (8) tick();
      resetb = 1'b1;

      // arbiter stays idle without a load
      req = '1;
      repeat (20) tick();
      check_equal("grants before load", winners.size(), 0);

      load_weights(4'd1, 4'd1, 4'd1);
      wait_winners(3);
      check_equal("first winner", winners[0], 0);
      check_equal("second winner", winners[1], 1);
      check_equal("third winner", winners[2], 2);

      quiesce_and_load(4'd3, 4'd1, 4'd2);
      req = '1;
      wait_winners(6);
      check_equal("round grants req 0", count_of(winners, 0), 3);
      check_equal("round grants req 1", count_of(winners, 1), 1);
      check_equal("round grants req 2", count_of(winners, 2), 2);

      // requester 1 has weight 0 and requester 2 drops out for a while
      fixed_len = 0;
      quiesce_and_load(4'd2, 4'd0, 4'd3);
      req = 3'b111;
      repeat (20) tick();
      req = 3'b011;
      repeat (20) tick();
      req = 3'b111;
      repeat (20) tick();
      check_equal("grants to weight 0", count_of(winners, 1), 0);

      // reload in the middle of traffic
      repeat (5) tick();
      load_weights(4'd1, 4'd2, 4'd1);
      winners.delete();
      repeat (40) tick();
      check_equal("req 1 granted after reload", count_of(winners, 1) != 0, 1);

      load_weights(weight_t'(lfsr_bits(4)), weight_t'(lfsr_bits(4)), weight_t'(lfsr_bits(4)));
      repeat (RAND_CYCLES)
      begin
         req = req_vec_t'(lfsr_bits(NUM_REQ));
         tick();
      end

      if (u_wrr_arbiter.u_props.fail_count != 0)
      begin
         $display("an assertion on the arbiter failed");
         fail_run();
      end
      else
      begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

//--- wrr_arbiter.sv
module wrr_arbiter
(
   input  logic                                        clk,
   input  logic                                        resetb,
   input  logic                                        cfg_load,
   input  wrr_pkg::weight_t [wrr_pkg::NUM_REQ-1:0]     cfg_weights,
   input  wrr_pkg::req_vec_t                           req,
   input  wrr_pkg::req_vec_t                           end_access,
   output wrr_pkg::req_vec_t                           gnt
);

   import wrr_pkg::*;

   wrr_cfg_t cfg;        // weights, armed and update
   req_vec_t take;       // credit spent this cycle
   req_vec_t eligible;   // credit left
   logic     refill;

   // software loaded weight registers
   wrr_weight_regs u_weight_regs
   (
      .clk         (clk),
      .resetb      (resetb),
      .cfg_load    (cfg_load),
      .cfg_weights (cfg_weights),
      .cfg         (cfg)
   );

   wrr_credit_counters u_credit_counters
   (
      .clk      (clk),
      .resetb   (resetb),
      .cfg      (cfg),
      .take     (take),
      .refill   (refill),
      .eligible (eligible)
   );

   // rotating pick among requesters with credit
   wrr_grant_sel u_grant_sel
   (
      .clk        (clk),
      .resetb     (resetb),
      .cfg        (cfg),
      .req        (req),
      .end_access (end_access),
      .eligible   (eligible),
      .gnt        (gnt),
      .take       (take),
      .refill     (refill)
   );

endmodule

//--- wrr_arbiter_props.sv
module wrr_arbiter_props
(
   input logic                 clk,
   input logic                 resetb,
   input wrr_pkg::req_vec_t    req,
   input wrr_pkg::req_vec_t    end_access,
   input wrr_pkg::req_vec_t    gnt,
   input wrr_pkg::arb_state_t  state
);

   timeunit 1ns;
   timeprecision 1ps;

   import wrr_pkg::*;

   logic decide;
   int   fail_count = 0;   // failed properties so far

   // same decision condition as the grant logic
   assign decide = (state == ST_ARMED) && ((gnt == '0) || ((gnt & end_access) != '0));

   a_gnt_onehot : assert property (@(posedge clk) disable iff (!resetb) $onehot0(gnt))
      else
      begin
         $error("gnt has more than one bit set: %b", gnt);
         fail_count++;
      end

   a_idle_no_gnt : assert property (@(posedge clk) disable iff (!resetb)
                                    (state == ST_IDLE) |-> (gnt == '0))
      else
      begin
         $error("gnt set while idle");
         fail_count++;
      end

   a_gnt_hold : assert property (@(posedge clk) disable iff (!resetb)
                                 ((gnt != '0) && ((gnt & end_access) == '0)) |=> $stable(gnt))
      else
      begin
         $error("gnt changed without end of access");
         fail_count++;
      end

   // winner was requesting when it was picked
   a_gnt_req : assert property (@(posedge clk) disable iff (!resetb)
                                decide |=> ((gnt == '0) || ((gnt & $past(req)) != '0)))
      else
      begin
         $error("gnt given to a requester that was not requesting");
         fail_count++;
      end

endmodule

bind wrr_arbiter wrr_arbiter_props u_props
(
   .clk        (clk),
   .resetb     (resetb),
   .req        (req),
   .end_access (end_access),
   .gnt        (gnt),
   .state      (u_grant_sel.state)
);

//--- wrr_credit_counters.sv
module wrr_credit_counters
(
   input  logic                clk,
   input  logic                resetb,
   input  wrr_pkg::wrr_cfg_t   cfg,
   input  wrr_pkg::req_vec_t   take,
   input  logic                refill,
   output wrr_pkg::req_vec_t   eligible
);

   import wrr_pkg::*;

   weight_t [NUM_REQ-1:0] credit;
   weight_t [NUM_REQ-1:0] credit_nxt;
   logic                  reload;

   // new weights or an empty round both restart every counter
   assign reload = cfg.update | refill;

   always_comb
   begin
      for (int i = 0; i < NUM_REQ; i++)
      begin
         if (reload)
         begin
            credit_nxt[i] = cfg_weight(cfg, i);
         end
         else if (take[i])
         begin
            credit_nxt[i] = credit[i] - weight_t'(1);   // one grant spent
         end
         else
         begin
            credit_nxt[i] = credit[i];
         end
      end
   end

   always_ff @(posedge clk or negedge resetb)
   begin
      if (!resetb)
      begin
         credit <= '0;
      end
      else
      begin
         credit <= credit_nxt;
      end
   end

   // a requester may win while it still holds credit
   always_comb
   begin
      for (int i = 0; i < NUM_REQ; i++)
      begin
         eligible[i] = (credit[i] != '0);
      end
   end

endmodule

//--- wrr_grant_sel.sv
module wrr_grant_sel
(
   input  logic                clk,
   input  logic                resetb,
   input  wrr_pkg::wrr_cfg_t   cfg,
   input  wrr_pkg::req_vec_t   req,
   input  wrr_pkg::req_vec_t   end_access,
   input  wrr_pkg::req_vec_t   eligible,
   output wrr_pkg::req_vec_t   gnt,
   output wrr_pkg::req_vec_t   take,
   output logic                refill
);

   import wrr_pkg::*;

   arb_state_t state;
   arb_state_t state_nxt;
   req_vec_t   gnt_nxt;
   ptr_t       ptr;        // last winner
   ptr_t       ptr_nxt;
   req_vec_t   cand;
   req_vec_t   rel_cand;
   logic       decide;
   logic       hit;
   ptr_t       offset;
   ptr_t       win_idx;

   // requesters that may be granted right now
   assign cand = req & eligible;

   // bus is free, or the current owner is done
   assign decide = (state == ST_ARMED) &&
                   ((gnt == '0) || ((gnt & end_access) != '0));

   // rotate so that bit 0 is the requester after the last winner
   always_comb
   begin
      for (int j = 0; j < NUM_REQ; j++)
      begin
         rel_cand[j] = cand[(int'(ptr) + 1 + j) % NUM_REQ];
      end
   end

   // lowest set bit of the rotated vector wins
   always_comb
   begin
      hit    = 1'b0;
      offset = '0;
      for (int j = NUM_REQ - 1; j >= 0; j--)
      begin
         if (rel_cand[j])
         begin
            hit    = 1'b1;
            offset = ptr_t'(j);
         end
      end
   end

   // back to an absolute requester index
   assign win_idx = ptr_t'((int'(ptr) + 1 + int'(offset)) % NUM_REQ);

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
         begin
            if (cfg.armed)
            begin
               state_nxt = ST_ARMED;
            end
         end
         ST_ARMED:
         begin
            state_nxt = ST_ARMED;   // only reset leaves
         end
         default:
         begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_comb
   begin
      gnt_nxt = gnt;
      ptr_nxt = ptr;
      take    = '0;
      refill  = 1'b0;
      if (decide)
      begin
         if (hit)
         begin
            gnt_nxt = req_vec_t'(1) << win_idx;
            take    = req_vec_t'(1) << win_idx;   // spend the winner's credit
            ptr_nxt = win_idx;
         end
         else
         begin
            gnt_nxt = '0;
            refill  = 1'b1;   // nobody left with credit, start a new round
         end
      end
   end

   always_ff @(posedge clk or negedge resetb)
   begin
      if (!resetb)
      begin
         state <= ST_IDLE;
         gnt   <= '0;
         ptr   <= ptr_t'(NUM_REQ - 1);   // requester 0 searched first
      end
      else
      begin
         state <= state_nxt;
         gnt   <= gnt_nxt;
         ptr   <= ptr_nxt;
      end
   end

endmodule

//--- wrr_pkg.sv
package wrr_pkg;

   // requester count and weight width size every packed type below
   parameter int NUM_REQ  = 3;
   parameter int WEIGHT_W = 4;

   // width of the last-winner pointer
   parameter int PTR_W = $clog2(NUM_REQ);

   // one bit per requester, bit 0 is requester 0
   typedef logic [NUM_REQ-1:0] req_vec_t;

   // a single weight, also used for a credit count
   typedef logic [WEIGHT_W-1:0] weight_t;

   // index of a requester
   typedef logic [PTR_W-1:0] ptr_t;

   // Configuration seen by the credit counters and the grant logic.
   // weights[0] sits in the lowest bits.
   typedef struct packed
   {
      logic                    armed;    // first load seen
      logic                    update;   // one cycle after every load
      weight_t [NUM_REQ-1:0]   weights;
   } wrr_cfg_t;

   // arbiter stays idle until software has loaded weights once
   typedef enum logic
   {
      ST_IDLE  = 1'b0,
      ST_ARMED = 1'b1
   } arb_state_t;

   // weight of one requester out of a cfg word
   function automatic weight_t cfg_weight(input wrr_cfg_t cfg, input int idx);
      weight_t w;
      w = cfg.weights[idx];
      return w;
   endfunction

endpackage

//--- wrr_weight_regs.sv
module wrr_weight_regs
(
   input  logic                                        clk,
   input  logic                                        resetb,
   input  logic                                        cfg_load,
   input  wrr_pkg::weight_t [wrr_pkg::NUM_REQ-1:0]     cfg_weights,
   output wrr_pkg::wrr_cfg_t                           cfg
);

   import wrr_pkg::*;

   weight_t [NUM_REQ-1:0] weights_q;
   logic                  armed_q;
   logic                  update_q;

   // software visible weights, written by the load strobe
   always_ff @(posedge clk or negedge resetb)
   begin
      if (!resetb)
      begin
         weights_q <= '0;
      end
      else if (cfg_load)
      begin
         weights_q <= cfg_weights;
      end
   end

   // armed is sticky until reset
   always_ff @(posedge clk or negedge resetb)
   begin
      if (!resetb)
      begin
         armed_q <= 1'b0;
      end
      else if (cfg_load)
      begin
         armed_q <= 1'b1;
      end
   end

   // delayed strobe, tells the counters to reload
   always_ff @(posedge clk or negedge resetb)
   begin
      if (!resetb)
      begin
         update_q <= 1'b0;
      end
      else
      begin
         update_q <= cfg_load;
      end
   end

   always_comb
   begin
      cfg.armed   = armed_q;
      cfg.update  = update_q;
      cfg.weights = weights_q;
   end

endmodule
